/* rtl/lock_pkg.sv */
package lock_pkg;

  // Code storage geometry.
  localparam int CODE_DIGITS   = 20;
  localparam int MIN_CODE_LEN  = 4;
  localparam int MAX_CODE_LEN  = 12;
  localparam int MATCH_OFFSETS = 17;

  // Timing, in clock cycles unless noted.
  localparam int DEBOUNCE_CYCLES   = 4;
  localparam int WRONG_HOLD_CYCLES = 8;
  localparam int ERROR_BEEP_CYCLES = 6;
  localparam int BLOCK_CYCLES      = 40;
  localparam int MAX_TRIES         = 5;
  localparam int TICKS_PER_UNIT    = 4;

  // Wide enough for 63 units of TICKS_PER_UNIT and for BLOCK_CYCLES.
  localparam int TIMER_BITS = 8;

  typedef logic [3:0] digit_t;

  // Display and keypad symbols.
  localparam digit_t DIGIT_TRY    = 4'hA;
  localparam digit_t DIGIT_BLANK  = 4'hB;
  localparam digit_t DIGIT_ERROR  = 4'hE;
  localparam digit_t DIGIT_UNUSED = 4'hF;

  // Digit 0 is the newest key of an entry, or the last digit of a stored code.
  typedef digit_t [CODE_DIGITS-1:0] code_t;

  // Same layout as a code, but a digit of F means "don't care".
  localparam code_t CODE_EMPTY = '1;

  // Digit 5 is leftmost.
  typedef digit_t [5:0] display_t;

  typedef enum logic [3:0] {
    reset_wait,
    locked,
    validate,
    wrong_code,
    blocked,
    key_error,
    ajar,
    open,
    open_alarm,
    press_wait
  } lock_state_t;

endpackage

/* rtl/code_window_match.sv */
`timescale 1ns/10ps

module code_window_match import lock_pkg::*; (
  input  code_t entry,
  input  code_t stored,
  input  code_t mask,
  output logic  hit
);

  code_t shifted;
  logic  any_hit;

  // Slide the entry right one digit per offset, shifting F in from the top.
  always_comb begin
    any_hit = 1'b0;
    shifted = entry;
    for (int k = 0; k < MATCH_OFFSETS; k++) begin
      shifted = ~((~entry) >> (4 * k));
      if ((shifted | mask) == stored) begin
        any_hit = 1'b1;
      end
    end
  end

  // An all-ones mask marks a disabled slot.
  assign hit = any_hit && (mask != CODE_EMPTY);

endmodule

/* rtl/passcode_bank.sv */
`timescale 1ns/10ps

module passcode_bank import lock_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  code_load,
  input  code_t user_code_0,
  input  code_t user_code_1,
  input  code_t user_code_2,
  input  code_t user_code_3,
  input  code_t keypad_digits,
  input  logic  capture,
  input  logic  clear_entry,
  output logic  code_ok
);

  code_t      load_code [4];
  code_t      stored [4];
  code_t      mask [4];
  code_t      entry;
  logic [3:0] hits;

  // Zero over the code's digits, F above them; all F when the code is too short.
  function automatic code_t length_mask(code_t code);
    code_t m;
    int    len;
    len = MAX_CODE_LEN;
    for (int i = MAX_CODE_LEN - 1; i >= MIN_CODE_LEN; i--) begin
      if (code[i] == DIGIT_UNUSED) begin
        len = i;
      end
    end
    m = CODE_EMPTY;
    for (int i = 0; i < CODE_DIGITS; i++) begin
      if (i < len) begin
        m[i] = 4'h0;
      end
    end
    for (int i = 0; i < MIN_CODE_LEN; i++) begin
      if (code[i] == DIGIT_UNUSED) begin
        m = CODE_EMPTY;
      end
    end
    return m;
  endfunction

  assign load_code[0] = user_code_0;
  assign load_code[1] = user_code_1;
  assign load_code[2] = user_code_2;
  assign load_code[3] = user_code_3;

  // Digits past length 12 are forced to F so long codes compare as 12 digits.
  always_ff @(posedge clk) begin
    if (code_load) begin
      for (int i = 0; i < 4; i++) begin
        stored[i] <= load_code[i] | length_mask(load_code[i]);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        mask[i] <= CODE_EMPTY;
      end
    end else if (code_load) begin
      for (int i = 0; i < 4; i++) begin
        mask[i] <= length_mask(load_code[i]);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      entry <= CODE_EMPTY;
    end else if (clear_entry) begin
      entry <= CODE_EMPTY;
    end else if (capture) begin
      entry <= keypad_digits;
    end
  end

  for (genvar g = 0; g < 4; g++) begin : g_match
    code_window_match u_match (
      .entry  (entry),
      .stored (stored[g]),
      .mask   (mask[g]),
      .hit    (hits[g])
    );
  end

  assign code_ok = (|hits) && (entry != CODE_EMPTY);

endmodule

/* rtl/button_debounce.sv */
`timescale 1ns/10ps

module button_debounce import lock_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic inside_button,
  output logic press
);

  localparam int HOLD_BITS = $clog2(DEBOUNCE_CYCLES + 1);

  logic [HOLD_BITS-1:0] hold_cnt;
  logic                 held_long;

  assign held_long = (hold_cnt == HOLD_BITS'(DEBOUNCE_CYCLES));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_cnt <= '0;
      press    <= 1'b0;
    end else begin
      press <= 1'b0;
      if (inside_button) begin
        // Saturate so a long hold still gives a single press.
        if (!held_long) begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end else begin
        // Release edge.
        if (held_long) begin
          press <= 1'b1;
        end
        hold_cnt <= '0;
      end
    end
  end

endmodule

/* rtl/door_fsm.sv */
`timescale 1ns/10ps

module door_fsm import lock_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       door_sensor,
  input  logic       press,
  input  code_t      keypad_digits,
  input  logic       keypad_valid,
  input  logic       code_ok,
  input  logic [5:0] relock_time,
  input  logic [5:0] beep_time,
  output logic       capture,
  output logic       clear_entry,
  output display_t   display_digits,
  output logic       keypad_en,
  output logic       latch_locked,
  output logic       beep
);

  lock_state_t           state;
  logic [TIMER_BITS-1:0] cnt;
  logic [TIMER_BITS-1:0] relock_limit;
  logic [TIMER_BITS-1:0] beep_limit;
  logic [2:0]            tries;
  logic                  key_err;
  logic                  entry_ok;

  assign relock_limit = TIMER_BITS'(relock_time * TICKS_PER_UNIT);
  assign beep_limit   = TIMER_BITS'(beep_time * TICKS_PER_UNIT);

  // E or F as the newest symbol means the keypad flagged an error.
  assign key_err  = keypad_valid &&
                    (keypad_digits[0] == DIGIT_ERROR || keypad_digits[0] == DIGIT_UNUSED);
  assign entry_ok = keypad_valid && !key_err;

  assign capture     = (state == locked) && entry_ok && !press;
  assign clear_entry = (state == validate) && code_ok;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= reset_wait;
      cnt   <= '0;
      tries <= '0;
    end else begin
      case (state)
        reset_wait: begin
          if (!door_sensor) begin
            state <= locked;
          end
        end
        locked: begin
          cnt <= '0;
          if (key_err) begin
            state <= key_error;
          end else if (press) begin
            state <= ajar;
          end else if (entry_ok) begin
            state <= validate;
            tries <= tries + 1'b1;
          end
        end
        validate: begin
          cnt <= '0;
          if (code_ok) begin
            state <= ajar;
            tries <= '0;
          end else begin
            state <= wrong_code;
          end
        end
        wrong_code: begin
          if (cnt == TIMER_BITS'(WRONG_HOLD_CYCLES - 1)) begin
            cnt <= '0;
            if (tries >= 3'(MAX_TRIES)) begin
              state <= blocked;
            end else begin
              state <= locked;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        blocked: begin
          if (cnt == TIMER_BITS'(BLOCK_CYCLES - 1)) begin
            cnt   <= '0;
            tries <= '0;
            state <= locked;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        key_error: begin
          if (cnt == TIMER_BITS'(ERROR_BEEP_CYCLES - 1)) begin
            cnt   <= '0;
            state <= locked;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ajar: begin
          if (press) begin
            state <= press_wait;
          end else if (door_sensor) begin
            cnt   <= '0;
            state <= open;
          end else if (cnt >= relock_limit) begin
            state <= locked;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        open: begin
          if (!door_sensor) begin
            cnt   <= '0;
            state <= ajar;
          end else if (cnt >= beep_limit) begin
            state <= open_alarm;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        open_alarm: begin
          if (!door_sensor) begin
            cnt   <= '0;
            state <= ajar;
          end
        end
        press_wait: begin
          // Let the press pulse clear before the keypad is live again.
          if (!press) begin
            state <= locked;
          end
        end
        default: begin
          state <= reset_wait;
        end
      endcase
    end
  end

  always_comb begin
    display_digits = {6{DIGIT_BLANK}};
    keypad_en      = 1'b0;
    latch_locked   = 1'b1;
    beep           = 1'b0;
    case (state)
      reset_wait: begin
        latch_locked = 1'b0;
      end
      locked: begin
        keypad_en = 1'b1;
      end
      // Tries stays at MAX_TRIES while blocked, giving BAAAAA.
      wrong_code, blocked: begin
        for (int i = 0; i < 6; i++) begin
          if (i < int'(tries)) begin
            display_digits[i] = DIGIT_TRY;
          end
        end
      end
      key_error: begin
        beep = 1'b1;
      end
      ajar, open, press_wait: begin
        latch_locked = 1'b0;
      end
      open_alarm: begin
        latch_locked = 1'b0;
        beep         = 1'b1;
      end
      default: begin
        latch_locked = 1'b1;
      end
    endcase
  end

endmodule

/* rtl/door_lock_top.sv */
`timescale 1ns/10ps

module door_lock_top import lock_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       door_sensor,
  input  logic       inside_button,
  input  logic       code_load,
  input  code_t      user_code_0,
  input  code_t      user_code_1,
  input  code_t      user_code_2,
  input  code_t      user_code_3,
  input  logic [5:0] relock_time,
  input  logic [5:0] beep_time,
  input  code_t      keypad_digits,
  input  logic       keypad_valid,
  output display_t   display_digits,
  output logic       keypad_en,
  output logic       latch_locked,
  output logic       beep
);

  logic press;
  logic capture;
  logic clear_entry;
  logic code_ok;

  passcode_bank u_bank (
    .clk           (clk),
    .rst           (rst),
    .code_load     (code_load),
    .user_code_0   (user_code_0),
    .user_code_1   (user_code_1),
    .user_code_2   (user_code_2),
    .user_code_3   (user_code_3),
    .keypad_digits (keypad_digits),
    .capture       (capture),
    .clear_entry   (clear_entry),
    .code_ok       (code_ok)
  );

  button_debounce u_debounce (
    .clk           (clk),
    .rst           (rst),
    .inside_button (inside_button),
    .press         (press)
  );

  door_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .door_sensor    (door_sensor),
    .press          (press),
    .keypad_digits  (keypad_digits),
    .keypad_valid   (keypad_valid),
    .code_ok        (code_ok),
    .relock_time    (relock_time),
    .beep_time      (beep_time),
    .capture        (capture),
    .clear_entry    (clear_entry),
    .display_digits (display_digits),
    .keypad_en      (keypad_en),
    .latch_locked   (latch_locked),
    .beep           (beep)
  );

endmodule

/* verification/lock_checker.sv */
`timescale 1ns/10ps

module lock_checker import lock_pkg::*; (
  input  logic     clk,
  input  logic     check_stb,
  input  logic     timed_out,
  input  int       test_num,
  input  logic     exp_latch,
  input  logic     exp_kpen,
  input  logic     exp_beep,
  input  display_t exp_disp,
  input  logic     latch_locked,
  input  logic     keypad_en,
  input  logic     beep,
  input  display_t display_digits,
  output int       failed_tests
);

  int tests_run;
  int mismatches;

  initial begin
    tests_run    = 0;
    failed_tests = 0;
    mismatches   = 0;
  end

  task automatic compare_value(input string name, input logic [23:0] exp_v,
                               input logic [23:0] act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_v, act_v);
      mismatches++;
    end
  endtask

  // Outputs are read before this edge updates the FSM, matching the tb's sample.
  always @(posedge clk) begin
    if (check_stb) begin
      mismatches = 0;
      if (timed_out) begin
        $display("Test %0d timed out waiting for its expected outputs", test_num);
        mismatches++;
      end
      compare_value("latch_locked", 24'(exp_latch), 24'(latch_locked));
      compare_value("keypad_en", 24'(exp_kpen), 24'(keypad_en));
      compare_value("beep", 24'(exp_beep), 24'(beep));
      compare_value("display_digits", exp_disp, display_digits);
      tests_run++;
      if (mismatches != 0) begin
        failed_tests++;
        $display("Test %0d failed", test_num);
      end else begin
        $display("Test %0d ok", test_num);
      end
    end
  end

  task automatic report_counts();
    $display("Tests run: %0d, failed: %0d", tests_run, failed_tests);
  endtask

endmodule

/* verification/tb_door_lock.sv */
`timescale 1ns/10ps

module tb_door_lock import lock_pkg::*; ();

  localparam int OP_IDLE   = 0;
  localparam int OP_SENSOR = 1;
  localparam int OP_KEY    = 2;
  localparam int OP_BUTTON = 3;

  localparam display_t BLANK  = 24'hBBBBBB;
  localparam code_t    CODE4  = 80'hFFFF_FFFF_FFFF_FFFF_1234;
  localparam code_t    CODE12 = 80'hFFFF_FFFF_5678_9012_3456;
  localparam code_t    WRONG  = 80'hFFFF_FFFF_FFFF_FFFF_9999;
  localparam code_t    KEYERR = 80'hFFFF_FFFF_FFFF_FFFF_123E;

  typedef struct {
    int       op;
    code_t    code;
    int       len;
    int       hold;
    logic     sensor;
    logic     latch;
    logic     kpen;
    logic     bp;
    display_t disp;
    int       limit;
  } row_t;

  logic       clk, rst, door_sensor, inside_button, code_load, keypad_valid;
  code_t      user_code_0, user_code_1, user_code_2, user_code_3, keypad_digits;
  logic [5:0] relock_time, beep_time;
  display_t   display_digits;
  logic       keypad_en, latch_locked, beep;
  logic       check_stb, timed_out, exp_latch, exp_kpen, exp_beep;
  display_t   exp_disp;
  int         test_num, failed_tests;
  logic [15:0] lfsr;
  row_t       rows[$];

  door_lock_top DUT (.*);

  lock_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Filler digits 0 to 9, four LFSR bits each.
  task automatic random_digit(output digit_t d);
    logic [3:0] b;
    for (int i = 0; i < 4; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];
    end
    d = b % 4'd10;
  endtask

  // Two fillers after the code, three before it, F above.
  task automatic build_entry(input code_t code, input int len, output code_t e);
    digit_t d;
    e = '1;
    for (int i = 0; i < 2; i++) begin
      random_digit(d);
      e[i] = d;
    end
    for (int i = 0; i < len; i++) begin
      e[2 + i] = code[i];
    end
    for (int i = 0; i < 3; i++) begin
      random_digit(d);
      e[2 + len + i] = d;
    end
  endtask

  task automatic add_row(input int op, input code_t code, input int len, input int hold,
                         input logic sensor, input logic latch, input logic kpen,
                         input logic bp, input display_t disp, input int limit);
    row_t r;
    r = '{op, code, len, hold, sensor, latch, kpen, bp, disp, limit};
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    code_t e;
    case (r.op)
      OP_IDLE: begin
        repeat (r.hold) @(posedge clk);
      end
      OP_SENSOR: begin
        @(posedge clk);
        door_sensor <= r.sensor;
      end
      OP_KEY: begin
        if (r.len == 0) begin
          e = r.code;
        end else begin
          build_entry(r.code, r.len, e);
        end
        @(posedge clk);
        keypad_digits <= e;
        keypad_valid  <= 1'b1;
        @(posedge clk);
        keypad_valid  <= 1'b0;
      end
      OP_BUTTON: begin
        @(posedge clk);
        inside_button <= 1'b1;
        repeat (r.hold) @(posedge clk);
        inside_button <= 1'b0;
        repeat (4) @(posedge clk);
      end
      default: begin
      end
    endcase
  endtask

  task automatic wait_expect(input row_t r, input int idx);
    logic ok;
    ok = 1'b0;
    for (int n = 0; n < r.limit && !ok; n++) begin
      @(negedge clk);
      ok = (latch_locked === r.latch) && (keypad_en === r.kpen) &&
           (beep === r.bp) && (display_digits === r.disp);
    end
    exp_latch = r.latch;
    exp_kpen  = r.kpen;
    exp_beep  = r.bp;
    exp_disp  = r.disp;
    test_num  = idx;
    timed_out = !ok;
    check_stb = 1'b1;
    @(posedge clk);
    check_stb <= 1'b0;
    timed_out <= 1'b0;
  endtask

  initial begin
    rst           = 1'b1;
    door_sensor   = 1'b1;
    inside_button = 1'b0;
    code_load     = 1'b0;
    keypad_valid  = 1'b0;
    keypad_digits = '1;
    relock_time   = 6'd5;
    beep_time     = 6'd3;
    user_code_0   = CODE4;
    user_code_1   = CODE12;
    user_code_2   = '1;
    user_code_3   = '1;
    check_stb     = 1'b0;
    timed_out     = 1'b0;
    exp_latch     = 1'b0;
    exp_kpen      = 1'b0;
    exp_beep      = 1'b0;
    exp_disp      = BLANK;
    test_num      = 0;
    lfsr          = 16'd9;
    // Reset, power-up, then both codes among fillers.
    add_row(OP_IDLE, '1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0, BLANK, 2);
    add_row(OP_SENSOR, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 3);
    add_row(OP_KEY, CODE4, 4, 0, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 2);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 40);
    add_row(OP_KEY, CODE12, 12, 0, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 2);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 40);
    // Four wrong codes, then the blocking fifth.
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBBBBBA, 4);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 20);
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBBBBAA, 4);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 20);
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBBBAAA, 4);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 20);
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBBAAAA, 4);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 20);
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBAAAAA, 4);
    // Past the wrong-code hold the keypad is still blocked.
    add_row(OP_IDLE, '1, 0, WRONG_HOLD_CYCLES + 4, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBAAAAA, 1);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 70);
    add_row(OP_KEY, CODE4, 4, 0, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 2);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 40);
    // Keypad error leaves the try count alone.
    add_row(OP_KEY, KEYERR, 0, 0, 1'b0, 1'b1, 1'b0, 1'b1, BLANK, 3);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 15);
    add_row(OP_KEY, WRONG, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 24'hBBBBBA, 4);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 20);
    // Inside button: short hold ignored, long holds unlock and relock.
    add_row(OP_BUTTON, '1, 0, 1, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 1);
    add_row(OP_BUTTON, '1, 0, DEBOUNCE_CYCLES, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 4);
    add_row(OP_BUTTON, '1, 0, DEBOUNCE_CYCLES + 2, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 4);
    // Door opened while unlocked.
    add_row(OP_BUTTON, '1, 0, DEBOUNCE_CYCLES, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 4);
    add_row(OP_SENSOR, '1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0, BLANK, 2);
    // Half the beep time in, still quiet.
    add_row(OP_IDLE, '1, 0, 6, 1'b1, 1'b0, 1'b0, 1'b0, BLANK, 1);
    add_row(OP_IDLE, '1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b1, BLANK, 20);
    add_row(OP_SENSOR, '1, 0, 0, 1'b0, 1'b0, 1'b0, 1'b0, BLANK, 3);
    add_row(OP_IDLE, '1, 0, 0, 1'b0, 1'b1, 1'b1, 1'b0, BLANK, 40);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    code_load <= 1'b1;
    @(posedge clk);
    code_load <= 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      wait_expect(rows[i], i);
    end
    @(negedge clk);
    u_checker.report_counts();
    if (failed_tests == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/lock_pkg.sv
rtl/code_window_match.sv
rtl/passcode_bank.sv
rtl/button_debounce.sv
rtl/door_fsm.sv
rtl/door_lock_top.sv
verification/lock_checker.sv
verification/tb_door_lock.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_door_lock -f list.f -o sim_door_lock \
  > sim.log 2>&1 && ./obj_dir/sim_door_lock >> sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
